// File: sources.f
verilog/ddcPkg.sv
verilog/ddcRegs.sv
verilog/loGenerator.sv
verilog/complexMixer.sv
verilog/cicDecimator.sv
verilog/gainStage.sv
verilog/ddc.sv
sim/ddcTb.sv

// File: run.sh
#!/bin/bash
# Build the DDC testbench with Verilator, run it, and check the log
verilator --binary --timing -Wno-fatal -f sources.f --top-module ddcTb -o ddcSim \
    > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/ddcSim 2>&1 | tee sim.log
grep -q "Simulation passed" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// File: sim/ddcTb.sv
// DDC directed testbench
`timescale 1ns/10ps

module ddcTb;

    localparam int TIMEOUT_CYCLES = 4000;

    logic           clk;
    logic           rstN;
    logic           clkEn;
    logic           wr0, wr1, wr2, wr3;
    logic           clkEnOut;
    ddcPkg::addrT   addr;
    ddcPkg::wordT   din;
    ddcPkg::wordT   dout;
    ddcPkg::sampleT iIn, qIn;
    ddcPkg::sampleT iOut, qOut;

    int             cycleCount = 0;
    int             valueErrors = 0;
    int             otherErrors = 0;
    int             totalPulses = 0;
    integer         seed = 55;
    int             stbCycQ[$];
    int             outCycQ[$];
    ddcPkg::sampleT outIQ[$];
    ddcPkg::sampleT outQQ[$];

    ddc uut (
        .clk(clk), .rstN(rstN),
        .addr(addr), .din(din), .dout(dout),
        .wr0(wr0), .wr1(wr1), .wr2(wr2), .wr3(wr3),
        .clkEn(clkEn), .iIn(iIn), .qIn(qIn),
        .clkEnOut(clkEnOut), .iOut(iOut), .qOut(qOut)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    // Run limit
    initial begin
        while (cycleCount < TIMEOUT_CYCLES) @(posedge clk);
        $display("Run stopped after %0d cycles, an expected output never arrived", cycleCount);
        $display("Simulation failed");
        $finish;
    end

    // Record every output strobe with its cycle
    always @(negedge clk) begin
        if (clkEnOut === 1'b1) begin
            outIQ.push_back(iOut);
            outQQ.push_back(qOut);
            outCycQ.push_back(cycleCount);
            totalPulses++;
        end
    end

    // Round half up by 2^17 after scaling with the oscillator peak
    function automatic longint scaleByPeak(input longint x);
        longint v;
        v = (x * ddcPkg::LO_AMPLITUDE + 65536) >>> 17;
        return clampSample(v);
    endfunction

    function automatic longint applyGain(input longint x, input int e, input int m);
        return clampSample((x * m) >>> (15 + e));
    endfunction

    function automatic longint clampSample(input longint v);
        if (v > 131071) return 131071;
        if (v < -131072) return -131072;
        return v;
    endfunction

    task automatic reportValue(input string name, input longint got, input longint expected);
        valueErrors++;
        $display("error at %0t: %s = %0d, expected %0d", $time, name, got, expected);
    endtask

    task automatic reportOther(input string msg);
        otherErrors++;
        $display("At %0t: %s", $time, msg);
    endtask

    task automatic writeReg(input ddcPkg::addrT a, input ddcPkg::wordT d, input logic [3:0] lanes);
        @(posedge clk);
        #1;
        addr = a;
        din = d;
        {wr3, wr2, wr1, wr0} = lanes;
        @(posedge clk);
        #1;
        {wr3, wr2, wr1, wr0} = 4'b0;
    endtask

    task automatic checkReg(input ddcPkg::addrT a, input ddcPkg::wordT expected);
        @(posedge clk);
        #1;
        addr = a;
        @(negedge clk);
        if (dout != expected) reportValue("dout", dout, expected);
    endtask

    task automatic sendSample(input ddcPkg::sampleT x, input ddcPkg::sampleT y);
        @(posedge clk);
        #1;
        clkEn = 1'b1;
        iIn = x;
        qIn = y;
        stbCycQ.push_back(cycleCount);
    endtask

    task automatic idleCycle();
        @(posedge clk);
        #1;
        clkEn = 1'b0;
    endtask

    task automatic clearQueues();
        stbCycQ.delete();
        outCycQ.delete();
        outIQ.delete();
        outQQ.delete();
    endtask

    // Waits for n outputs, then makes sure no extra strobe follows
    task automatic collectOutputs(input int n);
        idleCycle();
        while (outIQ.size() < n) @(posedge clk);
        repeat (12) @(posedge clk);
        if (outIQ.size() != n) begin
            reportOther($sformatf("%0d output strobes arrived where %0d were expected",
                                  outIQ.size(), n));
        end
    endtask

    task automatic checkRegisters();
        checkReg(ddcPkg::ADDR_CONTROL, 32'h0);
        checkReg(ddcPkg::ADDR_FREQ, 32'h0);
        checkReg(ddcPkg::ADDR_GAIN, 32'(ddcPkg::GAIN_UNITY));
        checkReg(ddcPkg::ADDR_STATUS, 32'h0);
        checkReg(4'd7, 32'h0);
        writeReg(ddcPkg::ADDR_FREQ, 32'hA5A5_A5A5, 4'b0010);
        checkReg(ddcPkg::ADDR_FREQ, 32'h0000_A500);
        writeReg(ddcPkg::ADDR_FREQ, 32'h3C3C_3C3C, 4'b1000);
        checkReg(ddcPkg::ADDR_FREQ, 32'h3C00_A500);
        writeReg(ddcPkg::ADDR_GAIN, 32'h001F_1234, 4'b0100);
        checkReg(ddcPkg::ADDR_GAIN, 32'h001F_8000);
        writeReg(ddcPkg::ADDR_GAIN, 32'h0000_0012, 4'b0001);
        checkReg(ddcPkg::ADDR_GAIN, 32'h001F_8012);
        writeReg(ddcPkg::ADDR_CONTROL, 32'hFFFF_FFFF, 4'b1110);
        checkReg(ddcPkg::ADDR_CONTROL, 32'h0);
        writeReg(4'd9, 32'hFFFF_FFFF, 4'b1111);
        checkReg(4'd9, 32'h0);
        // Defaults again, with the CIC bypassed
        writeReg(ddcPkg::ADDR_FREQ, 32'h0, 4'b1111);
        writeReg(ddcPkg::ADDR_GAIN, 32'(ddcPkg::GAIN_UNITY), 4'b1111);
        writeReg(ddcPkg::ADDR_CONTROL, 32'h1, 4'b0001);
        checkReg(ddcPkg::ADDR_CONTROL, 32'h1);
    endtask

    task automatic runBypassPath();
        ddcPkg::sampleT x;
        ddcPkg::sampleT y;
        longint         expI[$];
        longint         expQ[$];
        clearQueues();
        for (int i = 0; i < 40; i++) begin
            x = ddcPkg::sampleT'($random(seed));
            y = ddcPkg::sampleT'($random(seed));
            expI.push_back(scaleByPeak(x));
            expQ.push_back(scaleByPeak(y));
            sendSample(x, y);
            if (($random(seed) & 3) == 0) idleCycle();
        end
        collectOutputs(40);
        for (int i = 0; i < 40; i++) begin
            if (outCycQ[i] - stbCycQ[i] != 5) begin
                reportOther($sformatf("sample %0d took %0d cycles instead of 5",
                                      i, outCycQ[i] - stbCycQ[i]));
            end
            if (outIQ[i] != expI[i]) reportValue("iOut", outIQ[i], expI[i]);
            if (outQQ[i] != expQ[i]) reportValue("qOut", outQQ[i], expQ[i]);
        end
    endtask

    // Quarter-rate LO turns each output by +90 degrees
    task automatic runRotation();
        writeReg(ddcPkg::ADDR_FREQ, 32'h4000_0000, 4'b1111);
        clearQueues();
        repeat (12) sendSample(18'sd12345, -18'sd54321);
        collectOutputs(12);
        if (outIQ[0] != scaleByPeak(12345)) reportValue("iOut", outIQ[0], scaleByPeak(12345));
        for (int i = 1; i < 12; i++) begin
            if (outIQ[i] != -longint'(outQQ[i-1])) begin
                reportValue("iOut", outIQ[i], -longint'(outQQ[i-1]));
            end
            if (outQQ[i] != outIQ[i-1]) reportValue("qOut", outQQ[i], outIQ[i-1]);
        end
        writeReg(ddcPkg::ADDR_FREQ, 32'h0, 4'b1111);
    endtask

    task automatic checkDecimation();
        longint expI;
        longint expQ;
        writeReg(ddcPkg::ADDR_CONTROL, 32'h0, 4'b0001);
        clearQueues();
        for (int i = 0; i < 48; i++) begin
            sendSample(-18'sd70000, 18'sd33333);
            if (i % 5 == 4) idleCycle();
        end
        collectOutputs(6);
        // One output per group of 8 inputs, 7 cycles after its last input
        for (int i = 0; i < 6; i++) begin
            if (outCycQ[i] - stbCycQ[8 * i + 7] != 7) begin
                reportOther($sformatf("decimated output %0d took %0d cycles instead of 7",
                                      i, outCycQ[i] - stbCycQ[8 * i + 7]));
            end
        end
        // Settled once the filter window holds only the constant
        expI = scaleByPeak(-70000);
        expQ = scaleByPeak(33333);
        for (int i = 2; i < 6; i++) begin
            if (outIQ[i] != expI) reportValue("iOut", outIQ[i], expI);
            if (outQQ[i] != expQ) reportValue("qOut", outQQ[i], expQ);
        end
        writeReg(ddcPkg::ADDR_CONTROL, 32'h1, 4'b0001);
    endtask

    task automatic sweepGain();
        int             exps[5] = '{0, 0, 3, 1, 20};
        int             mants[5] = '{65535, 16384, 40000, 65535, 65535};
        ddcPkg::sampleT xs[4] = '{120000, -131072, 5000, -777};
        ddcPkg::sampleT ys[4] = '{-120000, 99999, -3, 131071};
        longint         expI;
        longint         expQ;
        for (int k = 0; k < 5; k++) begin
            writeReg(ddcPkg::ADDR_GAIN, {11'b0, 5'(exps[k]), 16'(mants[k])}, 4'b1111);
            clearQueues();
            for (int j = 0; j < 4; j++) sendSample(xs[j], ys[j]);
            collectOutputs(4);
            for (int j = 0; j < 4; j++) begin
                expI = applyGain(scaleByPeak(xs[j]), exps[k], mants[k]);
                expQ = applyGain(scaleByPeak(ys[j]), exps[k], mants[k]);
                if (outIQ[j] != expI) reportValue("iOut", outIQ[j], expI);
                if (outQQ[j] != expQ) reportValue("qOut", outQQ[j], expQ);
            end
        end
        writeReg(ddcPkg::ADDR_GAIN, 32'(ddcPkg::GAIN_UNITY), 4'b1111);
    endtask

    task automatic checkStatusCount();
        checkReg(ddcPkg::ADDR_STATUS, 32'(totalPulses & 16'hFFFF));
    endtask

    initial begin
        rstN = 1'b0;
        clkEn = 1'b0;
        iIn = '0;
        qIn = '0;
        addr = '0;
        din = '0;
        {wr3, wr2, wr1, wr0} = 4'b0;
        repeat (4) @(posedge clk);
        #1;
        rstN = 1'b1;
        checkRegisters();
        runBypassPath();
        runRotation();
        checkDecimation();
        sweepGain();
        checkStatusCount();
        $display("Errors: %0d wrong values, %0d other failures", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: verilog/ddc.sv
// Digital down-converter top level
`timescale 1ns/10ps

module ddc (
    input  logic           clk,
    input  logic           rstN,
    input  ddcPkg::addrT   addr,
    input  ddcPkg::wordT   din,
    input  logic           wr0,
    input  logic           wr1,
    input  logic           wr2,
    input  logic           wr3,
    output ddcPkg::wordT   dout,
    input  logic           clkEn,
    input  ddcPkg::sampleT iIn,
    input  ddcPkg::sampleT qIn,
    output logic           clkEnOut,
    output ddcPkg::sampleT iOut,
    output ddcPkg::sampleT qOut
);

    logic           bypassCic;
    ddcPkg::freqT   centerFreq;
    logic           freqLoad;
    ddcPkg::expT    gainExp;
    ddcPkg::mantT   gainMant;
    ddcPkg::sampleT iReg, qReg;
    logic           inValid;
    ddcPkg::sampleT loCos, loSin;
    ddcPkg::sampleT mixI, mixQ;
    logic           mixValid;
    logic           cicEn;
    ddcPkg::sampleT cicI, cicQ;
    logic           cicValid;
    ddcPkg::sampleT selI, selQ;
    logic           selValid;
    ddcPkg::sampleT gainI, gainQ;
    logic           gainValid;

    ddcRegs regs (
        .clk(clk), .rstN(rstN),
        .addr(addr), .din(din), .dout(dout),
        .wr0(wr0), .wr1(wr1), .wr2(wr2), .wr3(wr3),
        .clkEnOut(clkEnOut),
        .bypassCic(bypassCic), .centerFreq(centerFreq), .freqLoad(freqLoad),
        .gainExp(gainExp), .gainMant(gainMant)
    );

    // Input held one cycle to meet the oscillator output
    always_ff @(posedge clk) begin
        if (clkEn) begin
            iReg <= iIn;
            qReg <= qIn;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            inValid <= 1'b0;
        end else begin
            inValid <= clkEn;
        end
    end

    loGenerator lo (
        .clk(clk), .rstN(rstN), .clkEn(clkEn),
        .centerFreq(centerFreq), .freqLoad(freqLoad),
        .loCos(loCos), .loSin(loSin)
    );

    complexMixer mixer (
        .clk(clk), .rstN(rstN), .clkEn(inValid),
        .aReal(iReg), .aImag(qReg), .bReal(loCos), .bImag(loSin),
        .pReal(mixI), .pImag(mixQ), .mixValid(mixValid)
    );

    // CIC is idle while bypassed, its state is kept
    assign cicEn = mixValid & ~bypassCic;

    cicDecimator cic (
        .clk(clk), .rstN(rstN), .clkEn(cicEn),
        .inI(mixI), .inQ(mixQ),
        .outI(cicI), .outQ(cicQ), .cicValid(cicValid)
    );

    assign selI     = bypassCic ? mixI : cicI;
    assign selQ     = bypassCic ? mixQ : cicQ;
    assign selValid = bypassCic ? mixValid : cicValid;

    gainStage gainIRail (
        .clk(clk), .clkEn(selValid), .din(selI),
        .gainExp(gainExp), .gainMant(gainMant), .dout(gainI)
    );

    gainStage gainQRail (
        .clk(clk), .clkEn(selValid), .din(selQ),
        .gainExp(gainExp), .gainMant(gainMant), .dout(gainQ)
    );

    always_ff @(posedge clk) begin
        if (!rstN) begin
            gainValid <= 1'b0;
            clkEnOut  <= 1'b0;
        end else begin
            gainValid <= selValid;
            clkEnOut  <= gainValid;
        end
    end

    // Output register
    always_ff @(posedge clk) begin
        if (gainValid) begin
            iOut <= gainI;
            qOut <= gainQ;
        end
    end

endmodule

// File: verilog/gainStage.sv
// Programmable gain with saturation
`timescale 1ns/10ps

module gainStage (
    input  logic           clk,
    input  logic           clkEn,
    input  ddcPkg::sampleT din,
    input  ddcPkg::expT    gainExp,
    input  ddcPkg::mantT   gainMant,
    output ddcPkg::sampleT dout
);

    logic signed [34:0] product;
    logic signed [34:0] shifted;
    logic [5:0]         shiftAmt;

    // Mantissa is unsigned with 15 fraction bits
    assign product  = din * $signed({1'b0, gainMant});
    assign shiftAmt = 6'd15 + 6'(gainExp);

    // Arithmetic shift rounds toward minus infinity
    assign shifted = product >>> shiftAmt;

    always_ff @(posedge clk) begin
        if (clkEn) begin
            if (shifted > 35'sd131071) begin
                dout <= 18'sd131071;
            end else if (shifted < -35'sd131072) begin
                dout <= -18'sd131072;
            end else begin
                dout <= ddcPkg::sampleT'(shifted);
            end
        end
    end

endmodule

// File: verilog/cicDecimator.sv
// Three-stage CIC decimator
`timescale 1ns/10ps

module cicDecimator (
    input  logic           clk,
    input  logic           rstN,
    input  logic           clkEn,
    input  ddcPkg::sampleT inI,
    input  ddcPkg::sampleT inQ,
    output ddcPkg::sampleT outI,
    output ddcPkg::sampleT outQ,
    output logic           cicValid
);

    // Rail 0 is I, rail 1 is Q
    ddcPkg::cicAccT railIn  [2];
    ddcPkg::cicAccT integ   [2][ddcPkg::CIC_STAGES];
    ddcPkg::cicAccT combDly [2][ddcPkg::CIC_STAGES];
    ddcPkg::cicAccT combOut [2][ddcPkg::CIC_STAGES];

    logic [$clog2(ddcPkg::DECIM_FACTOR)-1:0] decimCount;
    logic                                     combTrig;

    // Comb chain runs in the cycle after the last input of a group
    always_comb begin
        railIn[0] = inI;
        railIn[1] = inQ;
        for (int r = 0; r < 2; r++) begin
            combOut[r][0] = integ[r][ddcPkg::CIC_STAGES-1] - combDly[r][0];
            for (int s = 1; s < ddcPkg::CIC_STAGES; s++) begin
                combOut[r][s] = combOut[r][s-1] - combDly[r][s];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int r = 0; r < 2; r++) begin
                for (int s = 0; s < ddcPkg::CIC_STAGES; s++) begin
                    integ[r][s]   <= '0;
                    combDly[r][s] <= '0;
                end
            end
            decimCount <= '0;
            combTrig   <= 1'b0;
            cicValid   <= 1'b0;
        end else begin
            combTrig <= clkEn && (decimCount == ddcPkg::DECIM_FACTOR - 1);
            cicValid <= combTrig;

            // Integrators wrap freely, the combs undo the overflow
            if (clkEn) begin
                decimCount <= decimCount + 1'b1;
                for (int r = 0; r < 2; r++) begin
                    integ[r][0] <= integ[r][0] + railIn[r];
                    for (int s = 1; s < ddcPkg::CIC_STAGES; s++) begin
                        integ[r][s] <= integ[r][s] + integ[r][s-1];
                    end
                end
            end

            if (combTrig) begin
                for (int r = 0; r < 2; r++) begin
                    combDly[r][0] <= integ[r][ddcPkg::CIC_STAGES-1];
                    for (int s = 1; s < ddcPkg::CIC_STAGES; s++) begin
                        combDly[r][s] <= combOut[r][s-1];
                    end
                end
            end
        end
    end

    // Gain of 8^3 removed by the shift
    always_ff @(posedge clk) begin
        if (combTrig) begin
            outI <= ddcPkg::sampleT'(combOut[0][ddcPkg::CIC_STAGES-1] >>> ddcPkg::CIC_SHIFT);
            outQ <= ddcPkg::sampleT'(combOut[1][ddcPkg::CIC_STAGES-1] >>> ddcPkg::CIC_SHIFT);
        end
    end

endmodule

// File: verilog/complexMixer.sv
// Pipelined complex multiplier
`timescale 1ns/10ps

module complexMixer (
    input  logic           clk,
    input  logic           rstN,
    input  logic           clkEn,
    input  ddcPkg::sampleT aReal,
    input  ddcPkg::sampleT aImag,
    input  ddcPkg::sampleT bReal,
    input  ddcPkg::sampleT bImag,
    output ddcPkg::sampleT pReal,
    output ddcPkg::sampleT pImag,
    output logic           mixValid
);

    // Drop 17 fraction bits and clamp to the sample range
    function automatic ddcPkg::sampleT satRound(input logic signed [37:0] v);
        logic signed [37:0] shifted;
        shifted = v >>> 17;
        if (shifted > 38'sd131071) return 18'sd131071;
        if (shifted < -38'sd131072) return -18'sd131072;
        return ddcPkg::sampleT'(shifted);
    endfunction

    logic [1:0]         validPipe;
    logic signed [35:0] prodRR;
    logic signed [35:0] prodII;
    logic signed [35:0] prodRI;
    logic signed [35:0] prodIR;
    logic signed [37:0] sumReal;
    logic signed [37:0] sumImag;

    // Half an output LSB added for round-half-up
    always_comb begin
        sumReal = 38'(prodRR) - 38'(prodII) + 38'sd65536;
        sumImag = 38'(prodRI) + 38'(prodIR) + 38'sd65536;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            validPipe <= '0;
        end else begin
            validPipe <= {validPipe[0], clkEn};
        end
    end

    always_ff @(posedge clk) begin
        if (clkEn) begin
            prodRR <= aReal * bReal;
            prodII <= aImag * bImag;
            prodRI <= aReal * bImag;
            prodIR <= aImag * bReal;
        end
        if (validPipe[0]) begin
            pReal <= satRound(sumReal);
            pImag <= satRound(sumImag);
        end
    end

    assign mixValid = validPipe[1];

endmodule

// File: verilog/loGenerator.sv
// Quarter-wave table oscillator
`timescale 1ns/10ps

module loGenerator (
    input  logic           clk,
    input  logic           rstN,
    input  logic           clkEn,
    input  ddcPkg::freqT   centerFreq,
    input  logic           freqLoad,
    output ddcPkg::sampleT loCos,
    output ddcPkg::sampleT loSin
);

    // Entry k is sin(k*pi/128) scaled to the table peak, Taylor series in Q30
    function automatic logic [16:0] sineEntry(input int k);
        longint angle;
        longint angleSq;
        longint term;
        longint acc;
        int     n;
        angle = (longint'(k) * 64'sd3373259426) / (2 << ddcPkg::LO_TABLE_BITS);
        angleSq = (angle * angle) >>> 30;
        term = angle;
        acc = angle;
        for (n = 1; n < 7; n++) begin
            term = -(((term * angleSq) >>> 30) / (2 * n * (2 * n + 1)));
            acc = acc + term;
        end
        return 17'((acc * ddcPkg::LO_AMPLITUDE + (64'sd1 <<< 29)) >>> 30);
    endfunction

    logic [16:0] sineRom [2 ** ddcPkg::LO_TABLE_BITS];

    for (genvar k = 0; k < 2 ** ddcPkg::LO_TABLE_BITS; k++) begin : gRom
        assign sineRom[k] = sineEntry(k);
    end

    ddcPkg::freqT                   phase;
    ddcPkg::freqT                   curPhase;
    logic [1:0]                     quadrant;
    logic [ddcPkg::LO_TABLE_BITS:0] step;
    logic [ddcPkg::LO_TABLE_BITS:0] mirror;
    logic [ddcPkg::LO_TABLE_BITS:0] sinIdx;
    logic [ddcPkg::LO_TABLE_BITS:0] cosIdx;
    logic [16:0]                    sinMag;
    logic [16:0]                    cosMag;
    ddcPkg::sampleT                 sinVal;
    ddcPkg::sampleT                 cosVal;

    always_comb begin
        // A pending frequency load restarts the sequence at phase zero
        curPhase = freqLoad ? '0 : phase;
        quadrant = curPhase[31:30];
        step = {1'b0, curPhase[29 -: ddcPkg::LO_TABLE_BITS]};
        mirror = {1'b1, {ddcPkg::LO_TABLE_BITS{1'b0}}} - step;

        // Odd quadrants run the table backwards
        sinIdx = quadrant[0] ? mirror : step;
        cosIdx = quadrant[0] ? step : mirror;

        // Top index bit marks the quadrant edge, which is the exact peak
        sinMag = sinIdx[ddcPkg::LO_TABLE_BITS] ? 17'(ddcPkg::LO_AMPLITUDE)
                                               : sineRom[sinIdx[ddcPkg::LO_TABLE_BITS-1:0]];
        cosMag = cosIdx[ddcPkg::LO_TABLE_BITS] ? 17'(ddcPkg::LO_AMPLITUDE)
                                               : sineRom[cosIdx[ddcPkg::LO_TABLE_BITS-1:0]];

        sinVal = {1'b0, sinMag};
        cosVal = {1'b0, cosMag};
        if (quadrant[1]) sinVal = -sinVal;
        if (quadrant[1] ^ quadrant[0]) cosVal = -cosVal;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            phase <= '0;
        end else if (clkEn) begin
            phase <= curPhase + centerFreq;
        end else if (freqLoad) begin
            phase <= '0;
        end
    end

    // Lines up with the registered input sample
    always_ff @(posedge clk) begin
        if (clkEn) begin
            loCos <= cosVal;
            loSin <= sinVal;
        end
    end

endmodule

// File: verilog/ddcRegs.sv
// DDC control registers
`timescale 1ns/10ps

module ddcRegs (
    input  logic         clk,
    input  logic         rstN,
    input  ddcPkg::addrT addr,
    input  ddcPkg::wordT din,
    input  logic         wr0,
    input  logic         wr1,
    input  logic         wr2,
    input  logic         wr3,
    input  logic         clkEnOut,
    output ddcPkg::wordT dout,
    output logic         bypassCic,
    output ddcPkg::freqT centerFreq,
    output ddcPkg::expT  gainExp,
    output ddcPkg::mantT gainMant,
    output logic         freqLoad
);

    logic [15:0] outCount;
    logic        anyWrite;

    assign anyWrite = wr0 | wr1 | wr2 | wr3;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            bypassCic  <= 1'b0;
            centerFreq <= '0;
            gainExp    <= '0;
            gainMant   <= 16'(ddcPkg::GAIN_UNITY);
            freqLoad   <= 1'b0;
            outCount   <= '0;
        end else begin
            // Restart the oscillator phase after any frequency byte
            freqLoad <= anyWrite && (addr == ddcPkg::ADDR_FREQ);

            if (clkEnOut) begin
                outCount <= outCount + 1'b1;
            end

            case (addr)
                ddcPkg::ADDR_CONTROL: begin
                    if (wr0) bypassCic <= din[0];
                end
                ddcPkg::ADDR_FREQ: begin
                    if (wr0) centerFreq[7:0]   <= din[7:0];
                    if (wr1) centerFreq[15:8]  <= din[15:8];
                    if (wr2) centerFreq[23:16] <= din[23:16];
                    if (wr3) centerFreq[31:24] <= din[31:24];
                end
                ddcPkg::ADDR_GAIN: begin
                    if (wr0) gainMant[7:0]  <= din[7:0];
                    if (wr1) gainMant[15:8] <= din[15:8];
                    if (wr2) gainExp        <= din[20:16];
                end
                default: begin
                end
            endcase
        end
    end

    // Readback, STATUS is read-only
    always_comb begin
        case (addr)
            ddcPkg::ADDR_CONTROL: dout = {31'b0, bypassCic};
            ddcPkg::ADDR_FREQ:    dout = centerFreq;
            ddcPkg::ADDR_GAIN:    dout = {11'b0, gainExp, gainMant};
            ddcPkg::ADDR_STATUS:  dout = {16'b0, outCount};
            default:              dout = '0;
        endcase
    end

endmodule

// File: verilog/ddcPkg.sv
// DDC shared definitions
package ddcPkg;

    // Datapath sample, also used for the oscillator and mixer outputs
    typedef logic signed [17:0] sampleT;

    // Register bus
    typedef logic [31:0] wordT;
    typedef logic [3:0]  addrT;

    // Phase increment of the oscillator
    typedef logic [31:0] freqT;

    // CIC register, 18 bits plus 3 stages of log2(8) growth
    typedef logic signed [26:0] cicAccT;

    // Gain control fields
    typedef logic [4:0]  expT;
    typedef logic [15:0] mantT;

    // Register map
    localparam addrT ADDR_CONTROL = 4'd0;
    localparam addrT ADDR_FREQ    = 4'd1;
    localparam addrT ADDR_GAIN    = 4'd2;
    localparam addrT ADDR_STATUS  = 4'd3;

    // Decimator shape and its normalization shift
    localparam int DECIM_FACTOR = 8;
    localparam int CIC_STAGES   = 3;
    localparam int CIC_SHIFT    = 9;

    // Oscillator table
    localparam int LO_AMPLITUDE  = 131071;
    localparam int LO_TABLE_BITS = 6;

    // Mantissa value for a gain of one
    localparam int GAIN_UNITY = 32768;

endpackage
